// ==== source/tpuPkg.sv ====
// Shared sizes, opcode enum and packed structs for the scalar lane
// Instruction, source reference, operand bundle, write-back and result

package tpuPkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH      = 16;
	localparam int REG_COUNT       = 16;
	localparam int REG_INDEX_WIDTH = 4;
	localparam int BUFF_SIZE       = 8;
	localparam int BUFF_PTR_WIDTH  = 3;
	localparam int RETIRE_LEVEL    = 4;	// Occupancy above which retire is forced
	localparam int SRC_COUNT       = 3;	// Source operands per instruction

	typedef logic [DATA_WIDTH-1:0]      data_t;
	typedef logic [REG_INDEX_WIDTH-1:0] regIndex_t;

	typedef enum logic [2:0] {
		opLoad,	// Immediate write
		opAdd,
		opSub,
		opMul,	// Low half of product
		opMadd,	// a*b+c, low half
		opMax,	// Signed
		opAnd,
		opNop
	} opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// Packed bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcode_t   opcode;
		regIndex_t dst;
		regIndex_t src1;
		regIndex_t src2;
		regIndex_t src3;
		data_t     imm;
	} instr_t;

	typedef struct packed {
		logic      used;
		regIndex_t index;
	} srcRef_t;

	// Decode to execute
	typedef struct packed {
		opcode_t   opcode;
		regIndex_t dst;
		data_t     a;
		data_t     b;
		data_t     c;
		data_t     imm;
	} operands_t;

	typedef struct packed {
		logic      valid;
		regIndex_t dst;
		data_t     data;
	} writeBack_t;

	typedef struct packed {
		regIndex_t dst;
		data_t     data;
		logic      zero;
		logic      negative;
	} laneResult_t;

endpackage

// ==== source/laneDecode.sv ====
// Lane decode stage
// Source usage, pending-register scoreboard, issue gating, operand register

`timescale 1ns/1ps

module laneDecode (
	input  logic              clock,
	input  logic              reset,
	input  logic              issueValid,
	input  tpuPkg::instr_t    instr,
	input  logic              full,
	input  tpuPkg::writeBack_t writeBack,
	output tpuPkg::srcRef_t   srcRef1,
	output tpuPkg::srcRef_t   srcRef2,
	output tpuPkg::srcRef_t   srcRef3,
	input  tpuPkg::data_t     srcData1,
	input  tpuPkg::data_t     srcData2,
	input  tpuPkg::data_t     srcData3,
	output logic              issueReady,
	output tpuPkg::operands_t operands,
	output logic              operandsValid
);
	import tpuPkg::*;

	logic                 useAB;
	logic                 useC;
	logic                 writesDst;
	logic                 hazard;
	logic                 accept;
	logic [REG_COUNT-1:0] pending;
	logic [REG_COUNT-1:0] pendingNow;	// After this cycle's write-back
	logic [REG_COUNT-1:0] clearMask;
	logic [REG_COUNT-1:0] setMask;

	always_comb begin
		useAB = 1'b1;
		useC  = 1'b0;
		case (instr.opcode)
			opLoad, opNop: useAB = 1'b0;
			opMadd:        useC = 1'b1;
			default:       ;
		endcase
	end

	assign writesDst = (instr.opcode != opNop);
	assign srcRef1   = '{used: useAB, index: instr.src1};
	assign srcRef2   = '{used: useAB, index: instr.src2};
	assign srcRef3   = '{used: useC, index: instr.src3};

	always_comb begin
		for (int r = 0; r < REG_COUNT; r++) begin
			clearMask[r] = writeBack.valid & (writeBack.dst == REG_INDEX_WIDTH'(r));
		end
	end

	always_comb begin
		for (int r = 0; r < REG_COUNT; r++) begin
			setMask[r] = accept & writesDst & (instr.dst == REG_INDEX_WIDTH'(r));
		end
	end

	assign pendingNow = pending & ~clearMask;
	assign hazard     = (srcRef1.used & pendingNow[srcRef1.index])
		| (srcRef2.used & pendingNow[srcRef2.index])
		| (srcRef3.used & pendingNow[srcRef3.index])
		| (writesDst & pendingNow[instr.dst]);	// WAW hold
	assign issueReady = ~full & ~hazard;
	assign accept     = issueValid & issueReady;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending       <= '0;
			operandsValid <= 1'b0;
		end else begin
			pending       <= pendingNow | setMask;
			operandsValid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			operands <= '{opcode: instr.opcode, dst: instr.dst, a: srcData1,
				b: srcData2, c: srcData3, imm: instr.imm};
		end
	end

endmodule

// ==== source/bypassBuffer.sv ====
// Bypass buffer of recent write-backs
// Newest-match forwarding for three sources, oldest-first retirement
// into the register file

`timescale 1ns/1ps

module bypassBuffer (
	input  logic               clock,
	input  logic               reset,
	input  tpuPkg::writeBack_t store,
	input  logic               issued,
	input  tpuPkg::srcRef_t    srcRef1,
	input  tpuPkg::srcRef_t    srcRef2,
	input  tpuPkg::srcRef_t    srcRef3,
	input  tpuPkg::data_t      regData1,
	input  tpuPkg::data_t      regData2,
	input  tpuPkg::data_t      regData3,
	output tpuPkg::data_t      srcData1,
	output tpuPkg::data_t      srcData2,
	output tpuPkg::data_t      srcData3,
	output tpuPkg::writeBack_t retire,
	output logic               full
);
	import tpuPkg::*;

	// Ring storage
	logic [BUFF_SIZE-1:0]    entryValid;
	regIndex_t               entryIndex [BUFF_SIZE];
	data_t                   entryData  [BUFF_SIZE];

	logic [BUFF_PTR_WIDTH-1:0] wrPtr;
	logic [BUFF_PTR_WIDTH-1:0] rdPtr;
	logic [BUFF_PTR_WIDTH:0]   count;
	logic [BUFF_PTR_WIDTH-1:0] slot;

	logic doStore;
	logic doRetire;

	srcRef_t              srcList [SRC_COUNT];
	data_t                regList [SRC_COUNT];
	data_t                fwdList [SRC_COUNT];
	logic [BUFF_SIZE-1:0] match   [SRC_COUNT];

	assign srcList[0] = srcRef1;
	assign srcList[1] = srcRef2;
	assign srcList[2] = srcRef3;
	assign regList[0] = regData1;
	assign regList[1] = regData2;
	assign regList[2] = regData3;

	////////////////////////////////////////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		slot = '0;
		for (int s = 0; s < SRC_COUNT; s++) begin
			fwdList[s] = regList[s];
			for (int i = 0; i < BUFF_SIZE; i++) begin
				match[s][i] = entryValid[i] & srcList[s].used
					& (entryIndex[i] == srcList[s].index);
			end
			// Oldest slot first so the newest match is taken last
			for (int k = BUFF_SIZE; k > 0; k--) begin
				slot = wrPtr - BUFF_PTR_WIDTH'(k);
				if (match[s][slot]) begin
					fwdList[s] = entryData[slot];
				end
			end
			// Write-back landing this cycle is newer than any entry
			if (store.valid & srcList[s].used & (store.dst == srcList[s].index)) begin
				fwdList[s] = store.data;
			end
		end
	end

	assign srcData1 = fwdList[0];
	assign srcData2 = fwdList[1];
	assign srcData3 = fwdList[2];

	////////////////////////////////////////////////////////////////////////////
	// Store and retire
	////////////////////////////////////////////////////////////////////////////

	assign doStore  = store.valid;
	assign doRetire = (count != '0)
		& ((count > (BUFF_PTR_WIDTH + 1)'(RETIRE_LEVEL)) | ~issued);

	assign retire = '{valid: doRetire, dst: entryIndex[rdPtr], data: entryData[rdPtr]};
	assign full   = (count >= (BUFF_PTR_WIDTH + 1)'(BUFF_SIZE - 1));	// Room for one in flight

	always_ff @(posedge clock) begin
		if (reset) begin
			entryValid <= '0;
			wrPtr      <= '0;
			rdPtr      <= '0;
			count      <= '0;
		end else begin
			if (doRetire) begin
				entryValid[rdPtr] <= 1'b0;
				rdPtr             <= rdPtr + 1'b1;
			end
			if (doStore) begin
				entryValid[wrPtr] <= 1'b1;
				wrPtr             <= wrPtr + 1'b1;
			end
			case ({doStore, doRetire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (doStore) begin
			entryIndex[wrPtr] <= store.dst;
			entryData[wrPtr]  <= store.data;
		end
	end

endmodule

// ==== source/registerFile.sv ====
// Architectural register file, 16 x 16 bits
// Three asynchronous read ports, one write port fed by buffer retirement

`timescale 1ns/1ps

module registerFile (
	input  logic               clock,
	input  logic               reset,
	input  tpuPkg::writeBack_t retire,
	input  tpuPkg::srcRef_t    srcRef1,
	input  tpuPkg::srcRef_t    srcRef2,
	input  tpuPkg::srcRef_t    srcRef3,
	output tpuPkg::data_t      regData1,
	output tpuPkg::data_t      regData2,
	output tpuPkg::data_t      regData3
);
	import tpuPkg::*;

	data_t regs [REG_COUNT];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < REG_COUNT; r++) begin
				regs[r] <= '0;
			end
		end else if (retire.valid) begin
			regs[retire.dst] <= retire.data;
		end
	end

	// Unused sources read as zero
	assign regData1 = srcRef1.used ? regs[srcRef1.index] : '0;
	assign regData2 = srcRef2.used ? regs[srcRef2.index] : '0;
	assign regData3 = srcRef3.used ? regs[srcRef3.index] : '0;

endmodule

// ==== source/laneExecute.sv ====
// Two-stage integer datapath
// Stage one forms product or immediate plus the simple results,
// stage two adds the accumulator and selects by opcode

`timescale 1ns/1ps

module laneExecute (
	input  logic              clock,
	input  logic              reset,
	input  tpuPkg::operands_t operands,
	input  logic              operandsValid,
	output logic              execValid,
	output tpuPkg::regIndex_t execDst,
	output tpuPkg::data_t     execData
);
	import tpuPkg::*;

	logic      s1Valid;
	opcode_t   s1Opcode;
	regIndex_t s1Dst;
	data_t     s1Prod;	// Product, or immediate for opLoad
	data_t     s1Sum;
	data_t     s1Diff;
	data_t     s1And;
	data_t     s1Max;
	data_t     s1C;
	data_t     selData;

	////////////////////////////////////////////////////////////////////////////
	// Stage one
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= operandsValid & (operands.opcode != opNop);
		end
	end

	always_ff @(posedge clock) begin
		s1Opcode <= operands.opcode;
		s1Dst    <= operands.dst;
		s1Prod   <= (operands.opcode == opLoad) ? operands.imm : operands.a * operands.b;
		s1Sum    <= operands.a + operands.b;
		s1Diff   <= operands.a - operands.b;
		s1And    <= operands.a & operands.b;
		s1Max    <= ($signed(operands.a) > $signed(operands.b)) ? operands.a : operands.b;
		s1C      <= operands.c;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage two
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (s1Opcode)
			opLoad, opMul: selData = s1Prod;
			opMadd:        selData = s1Prod + s1C;	// Wraps at 16 bits
			opAdd:         selData = s1Sum;
			opSub:         selData = s1Diff;
			opMax:         selData = s1Max;
			opAnd:         selData = s1And;
			default:       selData = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) execValid <= 1'b0;
		else       execValid <= s1Valid;
	end

	always_ff @(posedge clock) begin
		execDst  <= s1Dst;
		execData <= selData;
	end

endmodule

// ==== source/laneResult.sv ====
// Result stage
// Result register, zero and negative flags, write-back forming

`timescale 1ns/1ps

module laneResult (
	input  logic               clock,
	input  logic               reset,
	input  logic               execValid,
	input  tpuPkg::regIndex_t  execDst,
	input  tpuPkg::data_t      execData,
	output tpuPkg::writeBack_t writeBack,
	output tpuPkg::laneResult_t result,
	output logic               resultValid
);
	import tpuPkg::*;

	regIndex_t resDst;
	data_t     resData;
	logic      zeroFlag;
	logic      negFlag;

	always_ff @(posedge clock) begin
		if (reset) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= execValid;
		end
	end

	always_ff @(posedge clock) begin
		resDst  <= execDst;
		resData <= execData;
	end

	assign zeroFlag = (resData == '0);
	assign negFlag  = resData[DATA_WIDTH-1];	// Sign bit

	// Same registered value feeds the buffer and the lane output
	assign writeBack = '{valid: resultValid, dst: resDst, data: resData};
	assign result    = '{dst: resDst, data: resData, zero: zeroFlag, negative: negFlag};

endmodule

// ==== source/vectorLane.sv ====
// Scalar lane top level
// Decode, bypass buffer, register file, execute and result stages

`timescale 1ns/1ps

module vectorLane (
	input  logic                clock,
	input  logic                reset,
	input  logic                issueValid,
	input  tpuPkg::instr_t      instr,
	output logic                issueReady,
	output tpuPkg::laneResult_t result,
	output logic                resultValid
);
	import tpuPkg::*;

	srcRef_t    srcRef1, srcRef2, srcRef3;
	data_t      regData1, regData2, regData3;
	data_t      srcData1, srcData2, srcData3;
	writeBack_t writeBack;
	writeBack_t retire;
	operands_t  operands;
	logic       operandsValid;
	logic       full;
	logic       issued;
	logic       execValid;
	regIndex_t  execDst;
	data_t      execData;

	assign issued = issueValid & issueReady;	// Accept condition

	laneDecode decode_inst (.clock(clock), .reset(reset), .issueValid(issueValid),
		.instr(instr), .full(full), .writeBack(writeBack), .srcRef1(srcRef1),
		.srcRef2(srcRef2), .srcRef3(srcRef3), .srcData1(srcData1), .srcData2(srcData2),
		.srcData3(srcData3), .issueReady(issueReady), .operands(operands),
		.operandsValid(operandsValid));

	bypassBuffer buffer_inst (.clock(clock), .reset(reset), .store(writeBack),
		.issued(issued), .srcRef1(srcRef1), .srcRef2(srcRef2), .srcRef3(srcRef3),
		.regData1(regData1), .regData2(regData2), .regData3(regData3),
		.srcData1(srcData1), .srcData2(srcData2), .srcData3(srcData3),
		.retire(retire), .full(full));

	registerFile regFile_inst (.clock(clock), .reset(reset), .retire(retire),
		.srcRef1(srcRef1), .srcRef2(srcRef2), .srcRef3(srcRef3),
		.regData1(regData1), .regData2(regData2), .regData3(regData3));

	laneExecute execute_inst (.clock(clock), .reset(reset), .operands(operands),
		.operandsValid(operandsValid), .execValid(execValid), .execDst(execDst),
		.execData(execData));

	laneResult result_inst (.clock(clock), .reset(reset), .execValid(execValid),
		.execDst(execDst), .execData(execData), .writeBack(writeBack),
		.result(result), .resultValid(resultValid));

endmodule

// ==== test/laneTb.sv ====
// Testbench for the scalar lane
// Clock and reset, directed and random instruction stimulus,
// reference model with an expected-result queue, assertion checks

`timescale 1ns/1ps

module laneTb;
	import tpuPkg::*;

	localparam int WAIT_LIMIT = 200;	// Cycles before a wait gives up

	logic        clock;
	logic        reset;
	logic        issueValid;
	instr_t      instr;
	logic        issueReady;
	laneResult_t result;
	logic        resultValid;

	data_t       modelRegs [REG_COUNT];
	laneResult_t expQ [$];
	int          expCycle [$];	// Cycle of acceptance per expected result
	int          cycleCount;
	int          valueErrors;
	int          protocolErrors;
	int          timeoutErrors;
	string       testName;

	vectorLane vectorLane_inst (.clock(clock), .reset(reset), .issueValid(issueValid),
		.instr(instr), .issueReady(issueReady), .result(result), .resultValid(resultValid));

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic int sourcesUsed(opcode_t op);
		int uses;
		case (op)
			opLoad, opNop: uses = 0;
			opMadd:        uses = 3;
			default:       uses = 2;
		endcase
		return uses;
	endfunction

	function automatic data_t expectedValue(opcode_t op, data_t a, data_t b, data_t c,
		data_t imm);
		logic [31:0] wide;
		data_t       value;
		wide = {16'h0, a} * {16'h0, b} + ((op == opMadd) ? {16'h0, c} : 32'h0);
		case (op)
			opLoad:        value = imm;
			opAdd:         value = a + b;
			opSub:         value = a - b;
			opMul, opMadd: value = wide[15:0];	// Low half only
			opMax:         value = ((a ^ 16'h8000) > (b ^ 16'h8000)) ? a : b;	// Offset binary
			default:       value = a & b;
		endcase
		return value;
	endfunction

	function automatic logic inFlight(regIndex_t idx);
		foreach (expQ[i]) begin
			if (expQ[i].dst == idx) return 1'b1;
		end
		return 1'b0;
	endfunction

	// True when the instruction needs a register that has not come back yet
	function automatic logic mustHold(instr_t ins);
		int   uses;
		logic hold;
		uses = sourcesUsed(ins.opcode);
		hold = (ins.opcode != opNop) && inFlight(ins.dst);
		if (uses >= 2) hold = hold || inFlight(ins.src1) || inFlight(ins.src2);
		if (uses == 3) hold = hold || inFlight(ins.src3);
		return hold;
	endfunction

	function automatic data_t randData();
		return data_t'($urandom());
	endfunction

	// Outputs sampled mid-cycle away from the driving edge
	always @(negedge clock) begin
		laneResult_t expected;
		data_t       value;
		int          latency;
		if (reset) begin
			for (int r = 0; r < REG_COUNT; r++) begin
				modelRegs[r] = '0;
			end
			expQ.delete();
			expCycle.delete();
			cycleCount = 0;
		end else begin
			cycleCount++;
			if (resultValid) begin
				assert (expQ.size() != 0) else begin
					$display("%s: result seen with no accepted instruction outstanding", testName);
					protocolErrors++;
				end
				if (expQ.size() != 0) begin
					expected = expQ.pop_front();
					latency  = cycleCount - expCycle.pop_front();
					assert (result == expected) else begin
						$display("error %s: expected r%0d=%h z%b n%b, actual r%0d=%h z%b n%b",
							testName, expected.dst, expected.data, expected.zero,
							expected.negative, result.dst, result.data, result.zero,
							result.negative);
						valueErrors++;
					end
					assert (latency == 4) else begin
						$display("error %s latency: expected 4, actual %0d", testName, latency);
						valueErrors++;
					end
				end
			end
			// This cycle's write-back is already popped
			if (issueValid) begin
				assert (!(issueReady && mustHold(instr))) else begin
					$display("%s: issue not held for a register still in flight", testName);
					protocolErrors++;
				end
			end
			if (issueValid && issueReady && instr.opcode != opNop) begin
				value = expectedValue(instr.opcode, modelRegs[instr.src1], modelRegs[instr.src2],
					modelRegs[instr.src3], instr.imm);
				modelRegs[instr.dst] = value;
				expected = '{dst: instr.dst, data: value, zero: (value == '0),
					negative: value[DATA_WIDTH-1]};
				expQ.push_back(expected);
				expCycle.push_back(cycleCount);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic sendInstr(input instr_t ins);
		int waited;
		waited = 0;
		issueValid <= 1'b1;
		instr      <= ins;
		@(negedge clock);
		while (!issueReady && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clock);
		end
		if (!issueReady) begin
			$display("%s: timed out waiting for issueReady", testName);
			timeoutErrors++;
		end
		@(posedge clock);	// Accepting edge
	endtask

	task automatic issueOp(opcode_t op, int dst, int s1, int s2, int s3, data_t imm);
		sendInstr('{opcode: op, dst: regIndex_t'(dst), src1: regIndex_t'(s1),
			src2: regIndex_t'(s2), src3: regIndex_t'(s3), imm: imm});
	endtask

	task automatic idle(int cycles);
		issueValid <= 1'b0;
		repeat (cycles) @(posedge clock);
	endtask

	task automatic drainResults();
		int waited;
		waited = 0;
		issueValid <= 1'b0;
		while (expQ.size() != 0 && waited < WAIT_LIMIT) begin
			waited++;
			@(posedge clock);
		end
		if (expQ.size() != 0) begin
			$display("%s: timed out with %0d results missing", testName, expQ.size());
			timeoutErrors++;
		end
		idle(6);	// A stray result would show up here
	endtask

	initial begin
		data_t   imm;
		opcode_t op;
		void'($urandom(32'h04f8_2ee2));
		reset          = 1'b1;
		issueValid     = 1'b0;
		instr          = '0;
		valueErrors    = 0;
		protocolErrors = 0;
		timeoutErrors  = 0;
		testName       = "reset";
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (issueReady && !resultValid) else begin
			$display("reset: issueReady not high or resultValid not low after reset");
			protocolErrors++;
		end
		@(posedge clock);

		testName = "loadAll";
		for (int r = 0; r < REG_COUNT; r++) begin
			imm = (r == 0) ? 16'h0000 : (r == 1) ? 16'h8000 : randData();
			issueOp(opLoad, r, 0, 0, 0, imm);
		end
		drainResults();

		// opNop is the last opcode and must give no result
		testName = "opcodes";
		for (int k = 1; k < 8; k++) begin
			for (int n = 0; n < 12; n++) begin
				issueOp(opLoad, 1, 0, 0, 0, randData());
				issueOp(opLoad, 2, 0, 0, 0, randData());
				issueOp(opLoad, 3, 0, 0, 0, randData());
				issueOp(opcode_t'(3'(k)), 4 + n % 8, 1, 2, 3, randData());
			end
		end
		drainResults();

		testName = "chain";
		issueOp(opLoad, 5, 0, 0, 0, randData());
		for (int n = 0; n < 24; n++) begin
			op = opcode_t'(3'(1 + $urandom_range(5)));	// opAdd through opAnd
			issueOp(op, 5 + (n + 1) % 3, 5 + n % 3, 5 + (n + 2) % 3, 5 + n % 3, randData());
		end
		drainResults();

		testName = "burst";
		for (int n = 0; n < 48; n++) begin
			issueOp(opLoad, $urandom_range(15), 0, 0, 0, randData());
		end
		for (int r = 0; r < REG_COUNT; r++) begin
			issueOp(opAnd, r, r, r, 0, 16'h0);	// Reads back through the buffer
		end
		idle(20);
		for (int r = 0; r < REG_COUNT; r++) begin
			issueOp(opAnd, r, r, r, 0, 16'h0);
		end
		drainResults();

		testName = "stream";
		for (int n = 0; n < 300; n++) begin
			if ($urandom_range(3) == 0) idle(1 + $urandom_range(2));
			issueOp(opcode_t'(3'($urandom_range(7))), $urandom_range(15), $urandom_range(15),
				$urandom_range(15), $urandom_range(15), randData());
		end
		drainResults();

		$display("valueErrors=%0d protocolErrors=%0d timeoutErrors=%0d",
			valueErrors, protocolErrors, timeoutErrors);
		if (valueErrors + protocolErrors + timeoutErrors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
source/tpuPkg.sv
source/laneDecode.sv
source/bypassBuffer.sv
source/registerFile.sv
source/laneExecute.sv
source/laneResult.sv
source/vectorLane.sv
test/laneTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the lane testbench with Verilator, run it and scan the log for failure

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps --top-module laneTb \
	-f tb.f -o laneSim \
	&& ./obj_dir/laneSim > sim.log 2>&1 \
	|| { echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
	|| { echo "no failure found in log"; exit 0; }
